//--- rv_buyruk_pkg.sv
// rv32i subset encodings, opcode and funct constants, base vector types
`default_nettype none

package rv_buyruk_pkg;

    typedef logic [31:0] buyruk_t;
    typedef logic [31:0] veri_t;
    typedef logic [31:0] ps_t;
    typedef logic [4:0]  yazmac_adres_t;

    // ------------------------------
    // opcodes.
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // ------------------------------
    // funct3 and funct7 of the supported ops.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_ADDI    = 3'b000;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_TEMEL   = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // addi x0, x0, 0.
    localparam buyruk_t NOP_BUYRUK = 32'h0000_0013;
    localparam ps_t     RESET_PS   = 32'h0000_0000;

endpackage

`default_nettype wire

//--- cekirdek_pkg.sv
// pipeline micro-op and forwarding enums, stage-to-stage structs
`default_nettype none

package cekirdek_pkg;

    import rv_buyruk_pkg::*;

    typedef enum logic [3:0] {
        MI_YOK,
        MI_ADD,
        MI_SUB,
        MI_AND,
        MI_OR,
        MI_XOR,
        MI_LUI,
        MI_BEQ,
        MI_BNE,
        MI_JAL
    } mikroislem_e;

    // operand source in decode.
    typedef enum logic [1:0] {
        YON_YOK,
        YON_YRT,
        YON_GY
    } yonlendir_e;

    // ------------------------------
    typedef struct packed {
        logic    valid;
        buyruk_t buyruk;
        ps_t     ps;
    } gtr_cyo_t;

    typedef struct packed {
        logic          valid;
        mikroislem_e   mikroislem;
        yazmac_adres_t rd;
        veri_t         deger1;
        veri_t         deger2;
        veri_t         imm;
        ps_t           ps;
    } cyo_yrt_t;

    typedef struct packed {
        logic          valid;
        yazmac_adres_t rd;
        veri_t         sonuc;
        logic          yaz;
    } yrt_gy_t;

    typedef struct packed {
        logic          valid;
        yazmac_adres_t adres;
        veri_t         deger;
    } gy_yaz_t;

    typedef struct packed {
        logic gecerli;
        ps_t  ps;
    } atla_t;

endpackage

`default_nettype wire

//--- getir.sv
// fetch stage: program counter, memory request, wait and redirect handling
`timescale 1ns/1ns
`default_nettype none

module getir
    import rv_buyruk_pkg::*;
    import cekirdek_pkg::*;
(
    input  wire logic    clk_i,
    input  wire logic    rst_n_i,
    input  wire logic    l1b_bekle_i,
    input  wire buyruk_t l1b_deger_i,
    output logic         l1b_chip_select_n_o,
    output ps_t          l1b_adres_o,
    input  wire atla_t   atla_i,
    input  wire logic    bosalt_i,
    output gtr_cyo_t     cyo_o
);

    ps_t     ps_q;
    ps_t     hedef_q;
    logic    cs_n_q;
    logic    atla_bekle_q;
    logic    gecerli_q;
    buyruk_t buyruk_q;
    ps_t     buyruk_ps_q;
    logic    kabul;

    assign kabul = !cs_n_q && !l1b_bekle_i;

    // request every cycle once out of reset.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cs_n_q <= 1'b1;
        end else begin
            cs_n_q <= 1'b0;
        end
    end

    // ------------------------------
    // program counter.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ps_q         <= RESET_PS;
            atla_bekle_q <= 1'b0;
        end else if (atla_i.gecerli && !kabul && !cs_n_q) begin
            // memory still busy, address must hold.
            atla_bekle_q <= 1'b1;
        end else if (atla_i.gecerli) begin
            ps_q <= atla_i.ps;
        end else if (kabul && atla_bekle_q) begin
            ps_q         <= hedef_q;
            atla_bekle_q <= 1'b0;
        end else if (kabul) begin
            ps_q <= ps_q + 32'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (atla_i.gecerli) begin
            hedef_q <= atla_i.ps;
        end
    end

    // ------------------------------
    // fetched word toward decode.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gecerli_q <= 1'b0;
        end else begin
            gecerli_q <= kabul && !atla_bekle_q && !bosalt_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (kabul) begin
            buyruk_q    <= l1b_deger_i;
            buyruk_ps_q <= ps_q;
        end
    end

    assign l1b_chip_select_n_o = cs_n_q;
    assign l1b_adres_o         = ps_q;
    assign cyo_o               = '{valid: gecerli_q, buyruk: buyruk_q, ps: buyruk_ps_q};

endmodule

`default_nettype wire

//--- coz_yazmacoku.sv
// decode stage: decoder, register file, operand forwarding, decode register
`timescale 1ns/1ns
`default_nettype none

module coz_yazmacoku
    import rv_buyruk_pkg::*;
    import cekirdek_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire gtr_cyo_t   gtr_i,
    input  wire gy_yaz_t    gy_yaz_i,
    input  wire veri_t      yrt_yonlendir_i,
    input  wire yonlendir_e yon1_i,
    input  wire yonlendir_e yon2_i,
    input  wire logic       bosalt_i,
    output yazmac_adres_t   rs1_adres_o,
    output yazmac_adres_t   rs2_adres_o,
    output logic            gecersiz_buyruk_o,
    output cyo_yrt_t        yrt_o
);

    buyruk_t       buyruk;
    logic [6:0]    opcode;
    logic [2:0]    f3;
    logic [6:0]    f7;
    yazmac_adres_t rs1;
    yazmac_adres_t rs2;
    mikroislem_e   mikroislem;
    veri_t         imm;
    logic          imm_sec;
    logic          bilinen;
    logic          yazar;
    veri_t         deger1;
    veri_t         deger2;
    veri_t         yazmaclar [32];

    logic          gecerli_q;
    mikroislem_e   mikroislem_q;
    yazmac_adres_t rd_q;
    veri_t         deger1_q;
    veri_t         deger2_q;
    veri_t         imm_q;
    ps_t           ps_q;

    // empty slot decodes as a nop.
    assign buyruk = gtr_i.valid ? gtr_i.buyruk : NOP_BUYRUK;
    assign opcode = buyruk[6:0];
    assign f3     = buyruk[14:12];
    assign f7     = buyruk[31:25];
    assign rs1    = buyruk[19:15];
    assign rs2    = buyruk[24:20];

    // ------------------------------
    // decoder.
    always_comb begin
        mikroislem = MI_YOK;
        imm        = '0;
        imm_sec    = 1'b0;
        bilinen    = 1'b1;
        case (opcode)
            OP_R: begin
                case ({f7, f3})
                    {F7_TEMEL, F3_ADD_SUB}: mikroislem = MI_ADD;
                    {F7_SUB, F3_ADD_SUB}:   mikroislem = MI_SUB;
                    {F7_TEMEL, F3_XOR}:     mikroislem = MI_XOR;
                    {F7_TEMEL, F3_OR}:      mikroislem = MI_OR;
                    {F7_TEMEL, F3_AND}:     mikroislem = MI_AND;
                    default:                bilinen    = 1'b0;
                endcase
            end
            OP_I: begin
                imm     = {{20{buyruk[31]}}, buyruk[31:20]};
                imm_sec = 1'b1;
                if (f3 == F3_ADDI) begin
                    mikroislem = MI_ADD;
                end else begin
                    bilinen = 1'b0;
                end
            end
            OP_LUI: begin
                imm        = {buyruk[31:12], 12'b0};
                imm_sec    = 1'b1;
                mikroislem = MI_LUI;
            end
            OP_BRANCH: begin
                imm = {{20{buyruk[31]}}, buyruk[7], buyruk[30:25], buyruk[11:8], 1'b0};
                case (f3)
                    F3_BEQ:  mikroislem = MI_BEQ;
                    F3_BNE:  mikroislem = MI_BNE;
                    default: bilinen    = 1'b0;
                endcase
            end
            OP_JAL: begin
                imm = {{12{buyruk[31]}}, buyruk[19:12], buyruk[20], buyruk[30:21], 1'b0};
                mikroislem = MI_JAL;
            end
            default: bilinen = 1'b0;
        endcase
    end

    assign yazar = !(mikroislem inside {MI_YOK, MI_BEQ, MI_BNE});

    // wrong-path words are not flagged.
    assign gecersiz_buyruk_o = !bilinen && !bosalt_i;

    // ------------------------------
    // register file, x0 is never written.
    always_ff @(posedge clk_i) begin
        if (gy_yaz_i.valid && gy_yaz_i.adres != '0) begin
            yazmaclar[gy_yaz_i.adres] <= gy_yaz_i.deger;
        end
    end

    function automatic veri_t isleneni_sec(yazmac_adres_t adres, yonlendir_e yon);
        veri_t oku;
        if (adres == '0) begin
            oku = '0;
        end else begin
            oku = yazmaclar[adres];
        end
        case (yon)
            YON_YRT: return yrt_yonlendir_i;
            YON_GY:  return gy_yaz_i.deger;
            default: return oku;
        endcase
    endfunction

    always_comb begin
        deger1 = isleneni_sec(rs1, yon1_i);
        deger2 = imm_sec ? imm : isleneni_sec(rs2, yon2_i);
    end

    // ------------------------------
    // decode output register.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gecerli_q <= 1'b0;
        end else begin
            gecerli_q <= gtr_i.valid && !bosalt_i;
        end
    end

    // non-writing ops carry rd zero.
    always_ff @(posedge clk_i) begin
        mikroislem_q <= mikroislem;
        rd_q         <= yazar ? buyruk[11:7] : '0;
        deger1_q     <= deger1;
        deger2_q     <= deger2;
        imm_q        <= imm;
        ps_q         <= gtr_i.ps;
    end

    assign rs1_adres_o = rs1;
    assign rs2_adres_o = rs2;
    assign yrt_o = '{valid: gecerli_q, mikroislem: mikroislem_q, rd: rd_q,
                     deger1: deger1_q, deger2: deger2_q, imm: imm_q, ps: ps_q};

endmodule

`default_nettype wire

//--- yurut.sv
// execute stage: alu, branch compare, jump target, execute register
`timescale 1ns/1ns
`default_nettype none

module yurut
    import rv_buyruk_pkg::*;
    import cekirdek_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire cyo_yrt_t cyo_i,
    output atla_t         atla_o,
    output veri_t         yonlendir_deger_o,
    output yrt_gy_t       gy_o
);

    veri_t         sonuc;
    logic          esit;
    logic          atla;
    logic          yazar;
    logic          gecerli_q;
    yazmac_adres_t rd_q;
    veri_t         sonuc_q;
    logic          yaz_q;

    always_comb begin
        case (cyo_i.mikroislem)
            MI_ADD:  sonuc = cyo_i.deger1 + cyo_i.deger2;
            MI_SUB:  sonuc = cyo_i.deger1 - cyo_i.deger2;
            MI_AND:  sonuc = cyo_i.deger1 & cyo_i.deger2;
            MI_OR:   sonuc = cyo_i.deger1 | cyo_i.deger2;
            MI_XOR:  sonuc = cyo_i.deger1 ^ cyo_i.deger2;
            MI_LUI:  sonuc = cyo_i.imm;
            MI_JAL:  sonuc = cyo_i.ps + 32'd4;
            default: sonuc = '0;
        endcase
    end

    // ------------------------------
    // branch resolution.
    assign esit = cyo_i.deger1 == cyo_i.deger2;

    always_comb begin
        atla = 1'b0;
        if (cyo_i.valid) begin
            case (cyo_i.mikroislem)
                MI_BEQ:  atla = esit;
                MI_BNE:  atla = !esit;
                MI_JAL:  atla = 1'b1;
                default: atla = 1'b0;
            endcase
        end
    end

    assign atla_o = '{gecerli: atla, ps: cyo_i.ps + cyo_i.imm};

    assign yazar = cyo_i.rd != '0 && !(cyo_i.mikroislem inside {MI_YOK, MI_BEQ, MI_BNE});

    // ------------------------------
    // execute output register.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gecerli_q <= 1'b0;
        end else begin
            gecerli_q <= cyo_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_q    <= cyo_i.rd;
        sonuc_q <= sonuc;
        yaz_q   <= yazar;
    end

    assign yonlendir_deger_o = sonuc;
    assign gy_o = '{valid: gecerli_q, rd: rd_q, sonuc: sonuc_q, yaz: yaz_q};

endmodule

`default_nettype wire

//--- geri_yaz.sv
// writeback stage: commit register
`timescale 1ns/1ns
`default_nettype none

module geri_yaz
    import rv_buyruk_pkg::*;
    import cekirdek_pkg::*;
(
    input  wire logic    clk_i,
    input  wire logic    rst_n_i,
    input  wire yrt_gy_t yrt_i,
    output gy_yaz_t      yaz_o
);

    logic          gecerli_q;
    yazmac_adres_t adres_q;
    veri_t         deger_q;

    // only real writes to a non-zero rd retire here.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gecerli_q <= 1'b0;
        end else begin
            gecerli_q <= yrt_i.valid && yrt_i.yaz;
        end
    end

    always_ff @(posedge clk_i) begin
        adres_q <= yrt_i.rd;
        deger_q <= yrt_i.sonuc;
    end

    assign yaz_o = '{valid: gecerli_q, adres: adres_q, deger: deger_q};

endmodule

`default_nettype wire

//--- denetim_birimi.sv
// hazard unit: forwarding selects and flush on redirect
`timescale 1ns/1ns
`default_nettype none

module denetim_birimi
    import rv_buyruk_pkg::*;
    import cekirdek_pkg::*;
(
    input  wire yazmac_adres_t rs1_adres_i,
    input  wire yazmac_adres_t rs2_adres_i,
    input  wire yrt_gy_t       yrt_i,
    input  wire gy_yaz_t       gy_i,
    input  wire atla_t         atla_i,
    output yonlendir_e         yon1_o,
    output yonlendir_e         yon2_o,
    output logic               bosalt_o
);

    // newest producer wins.
    function automatic yonlendir_e kaynak_sec(yazmac_adres_t rs);
        if (rs == '0) begin
            return YON_YOK;
        end
        if (yrt_i.valid && yrt_i.yaz && yrt_i.rd == rs) begin
            return YON_YRT;
        end
        if (gy_i.valid && gy_i.adres == rs) begin
            return YON_GY;
        end
        return YON_YOK;
    endfunction

    always_comb begin
        yon1_o = kaynak_sec(rs1_adres_i);
        yon2_o = kaynak_sec(rs2_adres_i);
    end

    // taken branch or jump drops decode and fetch.
    assign bosalt_o = atla_i.gecerli;

endmodule

`default_nettype wire

//--- cekirdek.sv
// core top level: fetch, decode, execute, writeback and hazard unit
`timescale 1ns/1ns
`default_nettype none

module cekirdek
    import rv_buyruk_pkg::*;
    import cekirdek_pkg::*;
(
    input  wire logic    clk_i,
    input  wire logic    rst_n_i,
    input  wire logic    l1b_bekle_i,
    input  wire buyruk_t l1b_deger_i,
    output logic         l1b_chip_select_n_o,
    output ps_t          l1b_adres_o,
    output gy_yaz_t      gy_yaz_o,
    output logic         gecersiz_buyruk_o
);

    gtr_cyo_t      gtr_cyo;
    cyo_yrt_t      cyo_yrt;
    yrt_gy_t       yrt_gy;
    yrt_gy_t       yrt_ileri;
    gy_yaz_t       gy_ileri;
    atla_t         atla;
    veri_t         yonlendir_deger;
    yazmac_adres_t rs1_adres;
    yazmac_adres_t rs2_adres;
    yonlendir_e    yon1;
    yonlendir_e    yon2;
    logic          bosalt;

    // execute input seen as a producer, rd is already zero for non-writers.
    assign yrt_ileri = '{valid: cyo_yrt.valid, rd: cyo_yrt.rd,
                         sonuc: yonlendir_deger, yaz: cyo_yrt.valid};

    // register file write, same edge that loads the commit register.
    assign gy_ileri = '{valid: yrt_gy.valid && yrt_gy.yaz, adres: yrt_gy.rd,
                        deger: yrt_gy.sonuc};

    getir i_getir (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .l1b_bekle_i         (l1b_bekle_i),
        .l1b_deger_i         (l1b_deger_i),
        .l1b_chip_select_n_o (l1b_chip_select_n_o),
        .l1b_adres_o         (l1b_adres_o),
        .atla_i              (atla),
        .bosalt_i            (bosalt),
        .cyo_o               (gtr_cyo)
    );

    coz_yazmacoku i_coz_yazmacoku (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .gtr_i             (gtr_cyo),
        .gy_yaz_i          (gy_ileri),
        .yrt_yonlendir_i   (yonlendir_deger),
        .yon1_i            (yon1),
        .yon2_i            (yon2),
        .bosalt_i          (bosalt),
        .rs1_adres_o       (rs1_adres),
        .rs2_adres_o       (rs2_adres),
        .gecersiz_buyruk_o (gecersiz_buyruk_o),
        .yrt_o             (cyo_yrt)
    );

    yurut i_yurut (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .cyo_i             (cyo_yrt),
        .atla_o            (atla),
        .yonlendir_deger_o (yonlendir_deger),
        .gy_o              (yrt_gy)
    );

    geri_yaz i_geri_yaz (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .yrt_i   (yrt_gy),
        .yaz_o   (gy_yaz_o)
    );

    denetim_birimi i_denetim_birimi (
        .rs1_adres_i (rs1_adres),
        .rs2_adres_i (rs2_adres),
        .yrt_i       (yrt_ileri),
        .gy_i        (gy_ileri),
        .atla_i      (atla),
        .yon1_o      (yon1),
        .yon2_o      (yon2),
        .bosalt_o    (bosalt)
    );

endmodule

`default_nettype wire

//--- cekirdek_assert.sv
// concurrent checks on the core ports, bound into the top level
`timescale 1ns/1ns
`default_nettype none

module cekirdek_assert
    import rv_buyruk_pkg::*;
    import cekirdek_pkg::*;
(
    input wire logic    clk_i,
    input wire logic    rst_n_i,
    input wire logic    l1b_bekle_i,
    input wire logic    l1b_chip_select_n_o,
    input wire ps_t     l1b_adres_o,
    input wire gy_yaz_t gy_yaz_o
);

    // one reset edge seen, chip select must be off.
    cs_in_reset: assert property (@(posedge clk_i)
        (!rst_n_i && $past(!rst_n_i)) |-> l1b_chip_select_n_o)
        else $error("chip select active during reset");

    adres_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!l1b_chip_select_n_o && l1b_bekle_i) |=> $stable(l1b_adres_o))
        else $error("instruction address moved during a wait state");

    no_x0_commit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        gy_yaz_o.valid |-> gy_yaz_o.adres != '0)
        else $error("commit to register x0");

endmodule

bind cekirdek cekirdek_assert i_cekirdek_assert (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .l1b_bekle_i         (l1b_bekle_i),
    .l1b_chip_select_n_o (l1b_chip_select_n_o),
    .l1b_adres_o         (l1b_adres_o),
    .gy_yaz_o            (gy_yaz_o)
);

`default_nettype wire

//--- cekirdek_tb.sv
// core testbench: memory model, reference model, directed tests and watchdog
`timescale 1ns/1ns
`default_nettype none

module cekirdek_tb
    import rv_buyruk_pkg::*;
    import cekirdek_pkg::*;
();

    localparam int unsigned SEED  = 32'h0ae5_a93b;
    localparam int RESET_CYCLES   = 16;
    localparam int WORST_CYCLES   = 24;
    localparam int DRAIN_CYCLES   = 16;

    logic    clk_i;
    logic    rst_n_i;
    logic    l1b_bekle_i;
    buyruk_t l1b_deger_i;
    logic    l1b_chip_select_n_o;
    ps_t     l1b_adres_o;
    gy_yaz_t gy_yaz_o;
    logic    gecersiz_buyruk_o;

    buyruk_t       mem [256];
    buyruk_t       prog [$];
    veri_t         model_reg [32];
    yazmac_adres_t exp_adres [$];
    veri_t         exp_veri [$];
    int            exp_invalid;
    int            invalid_seen;
    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            budget = 64;
    int            wd_cyc = 0;
    bit            wait_en = 1'b0;

    cekirdek i_cekirdek (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .l1b_bekle_i         (l1b_bekle_i),
        .l1b_deger_i         (l1b_deger_i),
        .l1b_chip_select_n_o (l1b_chip_select_n_o),
        .l1b_adres_o         (l1b_adres_o),
        .gy_yaz_o            (gy_yaz_o),
        .gecersiz_buyruk_o   (gecersiz_buyruk_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // memory model, word and wait state for the next edge.
    initial begin
        void'($urandom(SEED));
        l1b_bekle_i = 1'b0;
        l1b_deger_i = NOP_BUYRUK;
        forever begin
            @(posedge clk_i);
            #2;
            l1b_bekle_i = wait_en && ($urandom % 3 == 0);
            l1b_deger_i = mem[l1b_adres_o[9:2]];
        end
    end

    // ------------------------------
    // instruction encoders.
    function automatic buyruk_t enc_r(logic [6:0] f7, logic [2:0] f3, yazmac_adres_t rd,
                                      yazmac_adres_t rs1, yazmac_adres_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic buyruk_t enc_addi(yazmac_adres_t rd, yazmac_adres_t rs1,
                                         logic [11:0] imm);
        return {imm, rs1, F3_ADDI, rd, OP_I};
    endfunction

    function automatic buyruk_t enc_lui(yazmac_adres_t rd, logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic buyruk_t enc_branch(logic [2:0] f3, yazmac_adres_t rs1,
                                           yazmac_adres_t rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic buyruk_t enc_jal(yazmac_adres_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // invalid opcode everywhere outside the program.
    function automatic buyruk_t fill_word(int idx);
        return {idx[24:0], 7'h7f};
    endfunction

    task automatic load_program();
        foreach (mem[i]) mem[i] = fill_word(i);
        foreach (prog[i]) mem[i] = prog[i];
    endtask

    // ------------------------------
    // reference model, runs until a jump to itself.
    task automatic build_expected();
        ps_t           pc;
        ps_t           next;
        buyruk_t       w;
        veri_t         a;
        veri_t         b;
        veri_t         v;
        veri_t         imm;
        yazmac_adres_t rd;
        logic          wr;
        bit            done;
        int            steps;
        pc = RESET_PS;
        done = 1'b0;
        steps = 0;
        exp_adres.delete();
        exp_veri.delete();
        exp_invalid = 0;
        while (!done && steps < 256) begin
            w = mem[pc[9:2]];
            rd = w[11:7];
            a = model_reg[w[19:15]];
            b = model_reg[w[24:20]];
            wr = 1'b1;
            v = '0;
            next = pc + 32'd4;
            case (w[6:0])
                OP_R: begin
                    case ({w[31:25], w[14:12]})
                        10'b0000000_000: v = a + b;
                        10'b0100000_000: v = a - b;
                        10'b0000000_100: v = a ^ b;
                        10'b0000000_110: v = a | b;
                        10'b0000000_111: v = a & b;
                        default: begin
                            wr = 1'b0;
                            exp_invalid++;
                        end
                    endcase
                end
                OP_I: begin
                    if (w[14:12] == 3'b000) begin
                        v = a + {{20{w[31]}}, w[31:20]};
                    end else begin
                        wr = 1'b0;
                        exp_invalid++;
                    end
                end
                OP_LUI: v = {w[31:12], 12'h000};
                OP_BRANCH: begin
                    wr = 1'b0;
                    imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    if (w[14:12] == 3'b000) begin
                        next = (a == b) ? pc + imm : next;
                    end else if (w[14:12] == 3'b001) begin
                        next = (a != b) ? pc + imm : next;
                    end else begin
                        exp_invalid++;
                    end
                end
                OP_JAL: begin
                    imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                    v = pc + 32'd4;
                    next = pc + imm;
                    done = (imm == '0);
                end
                default: begin
                    wr = 1'b0;
                    exp_invalid++;
                end
            endcase
            if (wr && rd != '0) begin
                exp_adres.push_back(rd);
                exp_veri.push_back(v);
                model_reg[rd] = v;
            end
            pc = next;
            steps++;
        end
    endtask

    // ------------------------------
    task automatic chk_adres(input string sig, input yazmac_adres_t got,
                             input yazmac_adres_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic chk_veri(input string sig, input veri_t got, input veri_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic chk_ps(input string sig, input ps_t got, input ps_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic chk_bit(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", sig, got, exp);
            errors++;
        end
    endtask

    // commit monitor, mid-cycle.
    always @(negedge clk_i) begin
        if (rst_n_i === 1'b1) begin
            if (gecersiz_buyruk_o === 1'b1) begin
                invalid_seen++;
            end
            if (gy_yaz_o.valid === 1'b1) begin
                if (exp_adres.size() == 0) begin
                    $display("unexpected extra commit to x%0d with value %h",
                             gy_yaz_o.adres, gy_yaz_o.deger);
                    errors++;
                end else begin
                    chk_adres("gy_yaz_o.adres", gy_yaz_o.adres, exp_adres.pop_front());
                    chk_veri("gy_yaz_o.deger", gy_yaz_o.deger, exp_veri.pop_front());
                end
            end
        end
    end

    // ------------------------------
    // test sequencing.
    task automatic apply_reset();
        @(posedge clk_i);
        #2;
        rst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
    endtask

    task automatic start_test(input bit with_wait);
        wait_en = with_wait;
        load_program();
        build_expected();
        budget += RESET_CYCLES + DRAIN_CYCLES + 8 + prog.size() * WORST_CYCLES;
        invalid_seen = 0;
        apply_reset();
    endtask

    task automatic wait_commits();
        int lim;
        int cyc;
        lim = prog.size() * WORST_CYCLES + 8;
        cyc = 0;
        while (exp_adres.size() != 0 && cyc < lim) begin
            @(posedge clk_i);
            cyc++;
        end
        if (exp_adres.size() != 0) begin
            $display("%0d expected commits never appeared within %0d cycles",
                     exp_adres.size(), lim);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        repeat (DRAIN_CYCLES) @(posedge clk_i);
        if (invalid_seen != exp_invalid) begin
            $display("invalid instruction flag seen %0d times, expected %0d",
                     invalid_seen, exp_invalid);
            errors++;
        end
        tests_run++;
        if (errors != e0) begin
            tests_failed++;
        end
        $display("test %-22s %s", name, (errors == e0) ? "ok" : "has errors");
    endtask

    task automatic run_test(input string name, input bit with_wait);
        int e0;
        e0 = errors;
        start_test(with_wait);
        wait_commits();
        finish_test(name, e0);
    endtask

    task automatic test_reset_request();
        int e0;
        e0 = errors;
        prog = '{enc_jal(5'd0, 21'd0)};
        start_test(1'b0);
        @(negedge clk_i);
        chk_bit("l1b_chip_select_n_o", l1b_chip_select_n_o, 1'b1);
        @(negedge clk_i);
        chk_bit("l1b_chip_select_n_o", l1b_chip_select_n_o, 1'b0);
        chk_ps("l1b_adres_o", l1b_adres_o, RESET_PS);
        finish_test("reset_request", e0);
    endtask

    // ------------------------------
    // programs.
    task automatic set_chain();
        prog = '{enc_addi(5'd1, 5'd0, 12'd5),
                 enc_addi(5'd2, 5'd1, 12'd7),
                 enc_r(F7_TEMEL, F3_ADD_SUB, 5'd3, 5'd1, 5'd2),
                 enc_r(F7_SUB, F3_ADD_SUB, 5'd4, 5'd3, 5'd1),
                 enc_r(F7_TEMEL, F3_XOR, 5'd5, 5'd4, 5'd3),
                 enc_r(F7_TEMEL, F3_OR, 5'd6, 5'd5, 5'd2),
                 enc_r(F7_TEMEL, F3_AND, 5'd7, 5'd6, 5'd4),
                 enc_r(F7_TEMEL, F3_ADD_SUB, 5'd7, 5'd7, 5'd7),
                 enc_r(F7_TEMEL, F3_ADD_SUB, 5'd7, 5'd7, 5'd7),
                 enc_addi(5'd8, 5'd7, 12'hffd),
                 enc_r(F7_SUB, F3_ADD_SUB, 5'd1, 5'd8, 5'd7),
                 enc_jal(5'd0, 21'd0)};
    endtask

    task automatic set_constants();
        prog = '{enc_lui(5'd9, 20'h12345),
                 enc_addi(5'd9, 5'd9, 12'h678),
                 enc_lui(5'd10, 20'hdeadc),
                 enc_addi(5'd10, 5'd10, 12'heef),
                 enc_addi(5'd0, 5'd1, 12'd9),
                 enc_lui(5'd0, 20'hfffff),
                 enc_r(F7_TEMEL, F3_ADD_SUB, 5'd0, 5'd9, 5'd10),
                 enc_r(F7_TEMEL, F3_XOR, 5'd11, 5'd9, 5'd10),
                 enc_jal(5'd0, 21'd0)};
    endtask

    task automatic set_branches();
        prog = '{enc_addi(5'd1, 5'd0, 12'd3),
                 enc_addi(5'd2, 5'd0, 12'd3),
                 enc_branch(F3_BEQ, 5'd1, 5'd2, 13'd12),
                 enc_addi(5'd3, 5'd0, 12'd1),
                 enc_addi(5'd3, 5'd0, 12'd2),
                 enc_branch(F3_BNE, 5'd1, 5'd2, 13'd8),
                 enc_addi(5'd4, 5'd0, 12'd4),
                 enc_branch(F3_BNE, 5'd1, 5'd4, 13'd12),
                 enc_addi(5'd5, 5'd0, 12'd5),
                 enc_addi(5'd5, 5'd0, 12'd6),
                 enc_branch(F3_BEQ, 5'd1, 5'd4, 13'd8),
                 enc_addi(5'd6, 5'd1, 12'd1),
                 enc_jal(5'd0, 21'd0)};
    endtask

    // funct7 of one is mul, outside the subset.
    task automatic set_jal_invalid();
        prog = '{enc_addi(5'd1, 5'd0, 12'd1),
                 enc_jal(5'd5, 21'd12),
                 enc_addi(5'd1, 5'd0, 12'd99),
                 enc_addi(5'd1, 5'd0, 12'd98),
                 enc_r(F7_TEMEL, F3_ADD_SUB, 5'd6, 5'd5, 5'd1),
                 enc_r(7'b0000001, F3_ADD_SUB, 5'd7, 5'd1, 5'd5),
                 enc_addi(5'd8, 5'd6, 12'd2),
                 enc_jal(5'd0, 21'd0)};
    endtask

    // ------------------------------
    initial begin
        rst_n_i = 1'b0;
        foreach (model_reg[i]) model_reg[i] = '0;
        test_reset_request();
        set_chain();
        run_test("dependent_chain", 1'b0);
        set_constants();
        run_test("lui_addi_x0", 1'b0);
        set_branches();
        run_test("beq_bne", 1'b0);
        set_jal_invalid();
        run_test("jal_invalid", 1'b0);
        set_chain();
        run_test("chain_wait_states", 1'b1);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // budget grows as each test starts.
    initial begin
        while (wd_cyc <= budget) begin
            @(posedge clk_i);
            wd_cyc++;
        end
        $display("watchdog stopped the run after %0d cycles", wd_cyc);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- cekirdek.f
rv_buyruk_pkg.sv
cekirdek_pkg.sv
getir.sv
coz_yazmacoku.sv
yurut.sv
geri_yaz.sv
denetim_birimi.sv
cekirdek.sv
cekirdek_assert.sv
cekirdek_tb.sv
